// ==== include/periph_macros.svh ====
/*
 * constants for the platform block: device map nibbles, register offsets,
 * tohost command codes and bus widths, included wherever they are needed
 */
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// APB data path
`define PERIPH_ADDR_W 32
`define PERIPH_DATA_W 32

// upper address nibble per device
`define DEV_TOHOST 4'h4
`define DEV_PLIC   4'h5
`define DEV_CLINT  4'h6

// plic context 0 claim/complete register
`define PLIC_CLAIM_OFS 28'h020_0004

// clint registers
`define CLINT_MTIME_LO_OFS 28'h000_BFF8
`define CLINT_MTIME_HI_OFS 28'h000_BFFC
`define CLINT_CMP_LO_OFS   28'h000_4000
`define CLINT_CMP_HI_OFS   28'h000_4004

// tohost sits at the base of its device window
`define TOHOST_OFS 28'h000_0000

// tohost commands, upper half of the word
`define CMD_PRINT_CHAR 16'h0101
`define CMD_POWER_OFF  16'h0001

// console, disk, ethernet, keyboard, mouse
`define IRQ_NUM 5

`endif

// ==== source/periph_pkg.sv ====
/*
 * types shared by the platform block modules and by its testbench
 */
`include "periph_macros.svh"

package periph_pkg;

    // master to slave
    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [`PERIPH_ADDR_W-1:0] paddr;
        logic [`PERIPH_DATA_W-1:0] pwdata;
    } apb_req_t;

    // slave to master
    typedef struct packed {
        logic [`PERIPH_DATA_W-1:0] prdata;
        logic                      pready;
        logic                      pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        SEL_PLIC,
        SEL_CLINT,
        SEL_TOHOST,
        SEL_NONE
    } dev_sel_t;

    // one decoded access, strobes last a single cycle
    typedef struct packed {
        logic                      wr;
        logic                      rd;
        logic [`PERIPH_ADDR_W-5:0] offset;
        logic [`PERIPH_DATA_W-1:0] wdata;
    } reg_access_t;

    typedef struct packed {
        logic [15:0] cmd;
        logic [15:0] payload;
    } tohost_cmd_t;

    // tohost word, seen as plain data or as command plus payload
    typedef union packed {
        logic [`PERIPH_DATA_W-1:0] raw;
        tohost_cmd_t               cmd_view;
    } tohost_word_u;

    typedef struct packed {
        logic       valid;
        logic [7:0] ch;
    } char_stream_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS,
        ST_RDWAIT
    } bus_state_e;

endpackage

// ==== source/periph_bus_ctrl.sv ====
/*
 * APB slave front end of the platform block: follows the transfer phases,
 * decodes the device nibble and hands one strobed access to the selected device
 */
`timescale 1ns/1ps
`include "periph_macros.svh"

module periph_bus_ctrl (
    input  logic                      CLK,
    input  logic                      i_arst_n,
    input  periph_pkg::apb_req_t      i_apb,
    output periph_pkg::apb_rsp_t      o_apb,
    output periph_pkg::reg_access_t   o_plic_acc,
    output periph_pkg::reg_access_t   o_clint_acc,
    output periph_pkg::reg_access_t   o_tohost_acc,
    input  logic [`PERIPH_DATA_W-1:0] i_plic_rdata,
    input  logic [`PERIPH_DATA_W-1:0] i_clint_rdata,
    input  logic [`PERIPH_DATA_W-1:0] i_tohost_rdata
);

    periph_pkg::bus_state_e    state_q;
    periph_pkg::bus_state_e    state_d;
    periph_pkg::bus_state_e    phase;
    periph_pkg::dev_sel_t      addr_sel;
    periph_pkg::dev_sel_t      sel_q;
    periph_pkg::reg_access_t   acc_base;
    logic                      first_acc;
    logic                      unmapped;
    logic [`PERIPH_DATA_W-1:0] rdata_mux;
    logic [`PERIPH_DATA_W-1:0] rdata_q;

    // keep the common access, raise strobes only for the hit device
    function automatic periph_pkg::reg_access_t gate_acc(
        input periph_pkg::reg_access_t acc,
        input logic                    hit
    );
        periph_pkg::reg_access_t res;
        res    = acc;
        res.wr = acc.wr && hit;
        res.rd = acc.rd && hit;
        return res;
    endfunction

    always_comb begin
        case (i_apb.paddr[`PERIPH_ADDR_W-1 -: 4])
            `DEV_PLIC:   addr_sel = periph_pkg::SEL_PLIC;
            `DEV_CLINT:  addr_sel = periph_pkg::SEL_CLINT;
            `DEV_TOHOST: addr_sel = periph_pkg::SEL_TOHOST;
            default:     addr_sel = periph_pkg::SEL_NONE;
        endcase
    end

    // setup shows up on the bus itself, later phases are tracked
    always_comb begin
        phase = state_q;
        if (state_q == periph_pkg::ST_IDLE && i_apb.psel && !i_apb.penable) begin
            phase = periph_pkg::ST_SETUP;
        end
    end

    assign first_acc = (phase == periph_pkg::ST_ACCESS);
    assign unmapped  = (sel_q == periph_pkg::SEL_NONE);

    always_comb begin
        case (phase)
            periph_pkg::ST_SETUP:  state_d = periph_pkg::ST_ACCESS;
            periph_pkg::ST_ACCESS: state_d = (i_apb.pwrite || unmapped) ?
                                             periph_pkg::ST_IDLE : periph_pkg::ST_RDWAIT;
            default:               state_d = periph_pkg::ST_IDLE;
        endcase
    end

    // device chosen once, at setup
    always_ff @(posedge CLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= periph_pkg::ST_IDLE;
            sel_q   <= periph_pkg::SEL_NONE;
        end else begin
            state_q <= state_d;
            if (phase == periph_pkg::ST_SETUP) begin
                sel_q <= addr_sel;
            end
        end
    end

    always_comb begin
        acc_base.wr     = first_acc && i_apb.pwrite;
        acc_base.rd     = first_acc && !i_apb.pwrite;
        acc_base.offset = i_apb.paddr[`PERIPH_ADDR_W-5:0];
        acc_base.wdata  = i_apb.pwdata;
    end

    assign o_plic_acc   = gate_acc(acc_base, sel_q == periph_pkg::SEL_PLIC);
    assign o_clint_acc  = gate_acc(acc_base, sel_q == periph_pkg::SEL_CLINT);
    assign o_tohost_acc = gate_acc(acc_base, sel_q == periph_pkg::SEL_TOHOST);

    always_comb begin
        case (sel_q)
            periph_pkg::SEL_PLIC:   rdata_mux = i_plic_rdata;
            periph_pkg::SEL_CLINT:  rdata_mux = i_clint_rdata;
            periph_pkg::SEL_TOHOST: rdata_mux = i_tohost_rdata;
            default:                rdata_mux = '0;
        endcase
    end

    // sampled in the strobe cycle, returned in the wait state
    always_ff @(posedge CLK) begin
        if (first_acc && !i_apb.pwrite) begin
            rdata_q <= rdata_mux;
        end
    end

    always_comb begin
        o_apb.pready  = (first_acc && (i_apb.pwrite || unmapped)) ||
                        (phase == periph_pkg::ST_RDWAIT);
        o_apb.pslverr = first_acc && unmapped;
        o_apb.prdata  = (phase == periph_pkg::ST_RDWAIT) ? rdata_q : '0;
    end

    // access phase always preceded by a setup
    a_penable_after_psel: assert property (@(posedge CLK) disable iff (!i_arst_n)
        $rose(i_apb.penable) |-> i_apb.psel && $past(i_apb.psel));

    a_one_strobe: assert property (@(posedge CLK) disable iff (!i_arst_n)
        $onehot0({o_plic_acc.wr | o_plic_acc.rd,
                  o_clint_acc.wr | o_clint_acc.rd,
                  o_tohost_acc.wr | o_tohost_acc.rd}));

    // master holds the request through the read wait state
    a_rdwait_stable: assert property (@(posedge CLK) disable iff (!i_arst_n)
        state_q == periph_pkg::ST_RDWAIT |->
            i_apb.psel && i_apb.penable && $stable(i_apb.paddr) && $stable(i_apb.pwrite));

endmodule

// ==== source/clint_timer.sv ====
/*
 * CLINT: free running mtime, mtimecmp written in 32-bit halves and the
 * machine timer interrupt
 */
`timescale 1ns/1ps
`include "periph_macros.svh"

module clint_timer (
    input  logic                      CLK,
    input  logic                      i_arst_n,
    input  periph_pkg::reg_access_t   i_acc,
    output logic [`PERIPH_DATA_W-1:0] o_rdata,
    output logic                      o_mtip
);

    localparam int TIME_W = 2 * `PERIPH_DATA_W;

    logic [TIME_W-1:0] mtime_q;
    logic [TIME_W-1:0] mtimecmp_q;
    logic              mtip_q;

    // one tick per clock
    always_ff @(posedge CLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    always_ff @(posedge CLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mtimecmp_q <= '1;
        end else if (i_acc.wr) begin
            if (i_acc.offset == `CLINT_CMP_LO_OFS) begin
                mtimecmp_q[`PERIPH_DATA_W-1:0] <= i_acc.wdata;
            end
            if (i_acc.offset == `CLINT_CMP_HI_OFS) begin
                mtimecmp_q[TIME_W-1:`PERIPH_DATA_W] <= i_acc.wdata;
            end
        end
    end

    // compare result shows one cycle late
    always_ff @(posedge CLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mtip_q <= 1'b0;
        end else begin
            mtip_q <= (mtime_q >= mtimecmp_q);
        end
    end

    assign o_mtip = mtip_q;

    always_comb begin
        case (i_acc.offset)
            `CLINT_MTIME_LO_OFS: o_rdata = mtime_q[`PERIPH_DATA_W-1:0];
            `CLINT_MTIME_HI_OFS: o_rdata = mtime_q[TIME_W-1:`PERIPH_DATA_W];
            `CLINT_CMP_LO_OFS:   o_rdata = mtimecmp_q[`PERIPH_DATA_W-1:0];
            `CLINT_CMP_HI_OFS:   o_rdata = mtimecmp_q[TIME_W-1:`PERIPH_DATA_W];
            default:             o_rdata = '0;
        endcase
    end

    // mtime never steps back or stalls
    a_mtime_rises: assert property (@(posedge CLK) disable iff (!i_arst_n)
        mtime_q != '1 |=> mtime_q > $past(mtime_q));

endmodule

// ==== source/plic_core.sv ====
/*
 * PLIC for the five external sources: pending and served masks, claim of the
 * lowest waiting id and completion through the same register
 */
`timescale 1ns/1ps
`include "periph_macros.svh"

module plic_core (
    input  logic                      CLK,
    input  logic                      i_arst_n,
    input  periph_pkg::reg_access_t   i_acc,
    input  logic [`IRQ_NUM-1:0]       i_irq_src,
    output logic [`PERIPH_DATA_W-1:0] o_rdata,
    output logic                      o_meip
);

    logic [`IRQ_NUM-1:0]       pending_q;
    logic [`IRQ_NUM-1:0]       served_q;
    logic [`IRQ_NUM-1:0]       eligible;
    logic [`IRQ_NUM-1:0]       pick_mask;
    logic [`IRQ_NUM-1:0]       done_mask;
    logic [`IRQ_NUM-1:0]       take_mask;
    logic [`IRQ_NUM-1:0]       clear_mask;
    logic [`PERIPH_DATA_W-1:0] claim_id;
    logic                      claim;
    logic                      complete;
    logic                      meip_q;

    assign eligible = pending_q & ~served_q;

    // priority pick, lowest index wins
    always_comb begin
        claim_id  = '0;
        pick_mask = '0;
        for (int i = `IRQ_NUM - 1; i >= 0; i--) begin
            if (eligible[i]) begin
                claim_id     = `PERIPH_DATA_W'(i + 1);
                pick_mask    = '0;
                pick_mask[i] = 1'b1;
            end
        end
    end

    // id written on completion, ids start at 1
    always_comb begin
        done_mask = '0;
        for (int i = 0; i < `IRQ_NUM; i++) begin
            if (i_acc.wdata == `PERIPH_DATA_W'(i + 1)) begin
                done_mask[i] = 1'b1;
            end
        end
    end

    assign claim      = i_acc.rd && (i_acc.offset == `PLIC_CLAIM_OFS);
    assign complete   = i_acc.wr && (i_acc.offset == `PLIC_CLAIM_OFS);
    assign take_mask  = claim ? pick_mask : '0;
    assign clear_mask = complete ? done_mask : '0;

    // a new pulse wins over a claim of the same source
    always_ff @(posedge CLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pending_q <= '0;
            served_q  <= '0;
            meip_q    <= 1'b0;
        end else begin
            pending_q <= (pending_q & ~take_mask) | i_irq_src;
            served_q  <= (served_q | take_mask) & ~clear_mask;
            meip_q    <= |eligible;
        end
    end

    assign o_meip  = meip_q;
    assign o_rdata = (i_acc.offset == `PLIC_CLAIM_OFS) ? claim_id : '0;

    // returned id points at a source that is pending and not yet served
    a_claim_fresh: assert property (@(posedge CLK) disable iff (!i_arst_n)
        claim && (claim_id != '0) |->
            pending_q[claim_id - 1] && !served_q[claim_id - 1]);

endmodule

// ==== source/tohost_unit.sv ====
/*
 * tohost command register: print command pulses a character out,
 * power-off command sets a flag that holds until reset
 */
`timescale 1ns/1ps
`include "periph_macros.svh"

module tohost_unit (
    input  logic                      CLK,
    input  logic                      i_arst_n,
    input  periph_pkg::reg_access_t   i_acc,
    output logic [`PERIPH_DATA_W-1:0] o_rdata,
    output periph_pkg::char_stream_t  o_char,
    output logic                      o_finish
);

    periph_pkg::tohost_word_u wr_word;
    periph_pkg::tohost_word_u word_q;
    periph_pkg::char_stream_t char_q;
    logic                     finish_q;
    logic                     wr_hit;

    assign wr_hit      = i_acc.wr && (i_acc.offset == `TOHOST_OFS);
    assign wr_word.raw = i_acc.wdata;

    always_ff @(posedge CLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            word_q   <= '0;
            char_q   <= '0;
            finish_q <= 1'b0;
        end else begin
            char_q.valid <= wr_hit && (wr_word.cmd_view.cmd == `CMD_PRINT_CHAR);
            if (wr_hit) begin
                word_q    <= wr_word;
                char_q.ch <= wr_word.cmd_view.payload[7:0];
            end
            // sticky until reset
            if (wr_hit && (wr_word.cmd_view.cmd == `CMD_POWER_OFF)) begin
                finish_q <= 1'b1;
            end
        end
    end

    assign o_char   = char_q;
    assign o_finish = finish_q;
    assign o_rdata  = (i_acc.offset == `TOHOST_OFS) ? word_q.raw : '0;

    // two writes are at least a setup apart on the bus
    a_char_single: assert property (@(posedge CLK) disable iff (!i_arst_n)
        o_char.valid |=> !o_char.valid);

endmodule

// ==== source/periph_top.sv ====
/*
 * platform block top: APB front end feeding the PLIC, CLINT and tohost devices
 */
`timescale 1ns/1ps
`include "periph_macros.svh"

module periph_top (
    input  logic                     CLK,
    input  logic                     i_arst_n,
    input  periph_pkg::apb_req_t     i_apb,
    output periph_pkg::apb_rsp_t     o_apb,
    input  logic [`IRQ_NUM-1:0]      i_irq_src,
    output logic                     o_meip,
    output logic                     o_mtip,
    output periph_pkg::char_stream_t o_char,
    output logic                     o_finish
);

    periph_pkg::reg_access_t   plic_acc;
    periph_pkg::reg_access_t   clint_acc;
    periph_pkg::reg_access_t   tohost_acc;
    logic [`PERIPH_DATA_W-1:0] plic_rdata;
    logic [`PERIPH_DATA_W-1:0] clint_rdata;
    logic [`PERIPH_DATA_W-1:0] tohost_rdata;

    periph_bus_ctrl u_bus (
        .CLK            (CLK),
        .i_arst_n       (i_arst_n),
        .i_apb          (i_apb),
        .o_apb          (o_apb),
        .o_plic_acc     (plic_acc),
        .o_clint_acc    (clint_acc),
        .o_tohost_acc   (tohost_acc),
        .i_plic_rdata   (plic_rdata),
        .i_clint_rdata  (clint_rdata),
        .i_tohost_rdata (tohost_rdata)
    );

    plic_core u_plic (
        .CLK       (CLK),
        .i_arst_n  (i_arst_n),
        .i_acc     (plic_acc),
        .i_irq_src (i_irq_src),
        .o_rdata   (plic_rdata),
        .o_meip    (o_meip)
    );

    clint_timer u_clint (
        .CLK      (CLK),
        .i_arst_n (i_arst_n),
        .i_acc    (clint_acc),
        .o_rdata  (clint_rdata),
        .o_mtip   (o_mtip)
    );

    tohost_unit u_tohost (
        .CLK      (CLK),
        .i_arst_n (i_arst_n),
        .i_acc    (tohost_acc),
        .o_rdata  (tohost_rdata),
        .o_char   (o_char),
        .o_finish (o_finish)
    );

endmodule

// ==== test/tb_periph.sv ====
/*
 * testbench for the platform block: APB transfers and interrupt pulses from an
 * xorshift stream, responses checked against a small model of the devices
 */
`timescale 1ns/1ps
`include "periph_macros.svh"

module tb_periph;

    localparam logic [31:0] SEED    = 32'h65b4;
    localparam int          N_BUS   = 16;
    localparam int          N_PLIC  = 40;
    localparam int          N_CHARS = 12;
    // the clint wait is worth about a dozen transfers
    localparam int          N_XFERS = 4 * N_BUS + 2 * N_PLIC + 12 + 2 * N_CHARS + 10;

    logic                     CLK;
    logic                     i_arst_n;
    periph_pkg::apb_req_t     i_apb;
    periph_pkg::apb_rsp_t     o_apb;
    logic [`IRQ_NUM-1:0]      i_irq_src;
    logic                     o_meip;
    logic                     o_mtip;
    periph_pkg::char_stream_t o_char;
    logic                     o_finish;

    logic [31:0]         rng_q = SEED;
    int                  n_errors;
    int                  n_checks;
    logic [`IRQ_NUM-1:0] m_pend;
    logic [`IRQ_NUM-1:0] m_served;
    logic [7:0]          chars_seen[$];
    logic [7:0]          chars_exp[$];

    periph_top DUT (
        .CLK       (CLK),
        .i_arst_n  (i_arst_n),
        .i_apb     (i_apb),
        .o_apb     (o_apb),
        .i_irq_src (i_irq_src),
        .o_meip    (o_meip),
        .o_mtip    (o_mtip),
        .o_char    (o_char),
        .o_finish  (o_finish)
    );

    always #5 CLK = ~CLK;

    // collects every character pulse
    always @(negedge CLK) begin
        if (o_char.valid) begin
            chars_seen.push_back(o_char.ch);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] rand_word();
        rng_q = xorshift32(rng_q);
        return rng_q;
    endfunction

    // model: lowest source pending and not served, ids count from 1
    function automatic logic [31:0] lowest_eligible();
        for (int i = 0; i < `IRQ_NUM; i++) begin
            if (m_pend[i] && !m_served[i]) begin
                return i + 1;
            end
        end
        return 0;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic apb_transfer(input logic wr, input logic [31:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err, output int cycles);
        @(posedge CLK);
        i_apb.psel    <= 1'b1;
        i_apb.penable <= 1'b0;
        i_apb.pwrite  <= wr;
        i_apb.paddr   <= addr;
        i_apb.pwdata  <= wdata;
        @(posedge CLK);
        i_apb.penable <= 1'b1;
        cycles = 2;
        @(negedge CLK);
        while (!o_apb.pready && cycles < 8) begin
            @(negedge CLK);
            cycles++;
        end
        if (!o_apb.pready) begin
            n_errors++;
            $display("transfer to %h was never answered with pready", addr);
        end
        rdata = o_apb.prdata;
        err   = o_apb.pslverr;
        @(posedge CLK);
        i_apb.psel    <= 1'b0;
        i_apb.penable <= 1'b0;
    endtask

    // mapped register access, handshake checked on the way
    task automatic reg_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        logic err;
        int   cycles;
        apb_transfer(wr, addr, wdata, rdata, err, cycles);
        check_eq(err, 0, "pslverr on a mapped address");
        check_eq(cycles, wr ? 2 : 3, "transfer length");
    endtask

    task automatic irq_pulse(input logic [`IRQ_NUM-1:0] mask);
        @(posedge CLK);
        i_irq_src <= mask;
        @(posedge CLK);
        i_irq_src <= '0;
        m_pend = m_pend | mask;
    endtask

    task automatic meip_check();
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        check_eq(o_meip, |(m_pend & ~m_served), "meip against model");
    endtask

    task automatic plic_claim();
        logic [31:0] id;
        logic [31:0] exp;
        exp = lowest_eligible();
        reg_access(1'b0, {`DEV_PLIC, `PLIC_CLAIM_OFS}, '0, id);
        check_eq(id, exp, "claimed id");
        if (exp != 0) begin
            m_pend[exp-1]   = 1'b0;
            m_served[exp-1] = 1'b1;
        end
        meip_check();
    endtask

    task automatic plic_complete(input int id);
        logic [31:0] rd;
        reg_access(1'b1, {`DEV_PLIC, `PLIC_CLAIM_OFS}, id, rd);
        if (id >= 1 && id <= `IRQ_NUM) begin
            m_served[id-1] = 1'b0;
        end
        meip_check();
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] r;
        logic [31:0] t0;
        logic [31:0] t1;
        logic [31:0] cmp;
        logic [31:0] word;
        logic [31:0] last_word;
        logic [3:0]  nib;
        logic        err;
        int          cycles;
        int          k;
        CLK       = 1'b0;
        i_arst_n  = 1'b0;
        i_apb     = '0;
        i_irq_src = '0;
        n_errors  = 0;
        n_checks  = 0;
        m_pend    = '0;
        m_served  = '0;
        repeat (5) @(posedge CLK);
        i_arst_n <= 1'b1;
        @(negedge CLK);
        check_eq({o_apb.pready, o_apb.pslverr, o_meip, o_mtip, o_finish, o_char.valid}, 0,
                 "outputs after reset");

        // unused offsets read zero, unmapped nibbles give an error
        for (int i = 0; i < N_BUS; i++) begin
            r = rand_word();
            case (r[30:29])
                2'd0:    nib = `DEV_PLIC;
                2'd1:    nib = `DEV_CLINT;
                default: nib = `DEV_TOHOST;
            endcase
            reg_access(1'b1, {nib, 16'h0010, r[11:2], 2'b00}, rand_word(), rd);
            reg_access(1'b0, {nib, 16'h0010, r[11:2], 2'b00}, '0, rd);
            check_eq(rd, 0, "read of an unused offset");
            nib = r[19:16];
            if (nib inside {`DEV_PLIC, `DEV_CLINT, `DEV_TOHOST}) begin
                nib = nib ^ 4'h8;
            end
            apb_transfer(1'b0, {nib, r[27:0]}, '0, rd, err, cycles);
            check_eq(err, 1, "pslverr on unmapped read");
            check_eq(rd, 0, "prdata on unmapped read");
            check_eq(cycles, 2, "unmapped transfer length");
            apb_transfer(1'b1, {nib, r[27:0]}, r, rd, err, cycles);
            check_eq(err, 1, "pslverr on unmapped write");
        end

        for (int i = 0; i < N_PLIC; i++) begin
            r = rand_word();
            case (r[1:0])
                2'd0, 2'd1: begin
                    irq_pulse(r[4 +: `IRQ_NUM]);
                    meip_check();
                end
                2'd2:    plic_claim();
                default: plic_complete(1 + r[15:8] % `IRQ_NUM);
            endcase
        end

        // empty the PLIC, then one source through claim, re-pulse and completion
        for (int id = 1; id <= `IRQ_NUM; id++) begin
            plic_complete(id);
        end
        repeat (`IRQ_NUM) plic_claim();
        for (int id = 1; id <= `IRQ_NUM; id++) begin
            plic_complete(id);
        end
        k = 1 + rand_word() % `IRQ_NUM;
        irq_pulse(1 << (k - 1));
        meip_check();
        plic_claim();
        irq_pulse(1 << (k - 1));
        meip_check();
        plic_claim();
        plic_complete(k);
        plic_claim();
        plic_complete(k);

        reg_access(1'b0, {`DEV_CLINT, `CLINT_MTIME_LO_OFS}, '0, t0);
        reg_access(1'b0, {`DEV_CLINT, `CLINT_MTIME_LO_OFS}, '0, t1);
        check_eq(t1 > t0, 1, "mtime increasing");
        reg_access(1'b0, {`DEV_CLINT, `CLINT_MTIME_HI_OFS}, '0, rd);
        k   = 20 + rand_word() % 41;
        cmp = t1 + k;
        reg_access(1'b1, {`DEV_CLINT, `CLINT_CMP_HI_OFS}, rd, r);
        reg_access(1'b1, {`DEV_CLINT, `CLINT_CMP_LO_OFS}, cmp, r);
        @(negedge CLK);
        check_eq(o_mtip, 0, "mtip right after the compare write");
        repeat (k + 4) @(posedge CLK);
        @(negedge CLK);
        check_eq(o_mtip, 1, "mtip after the compare time");
        reg_access(1'b0, {`DEV_CLINT, `CLINT_CMP_LO_OFS}, '0, r);
        check_eq(r, cmp, "mtimecmp low half");
        reg_access(1'b0, {`DEV_CLINT, `CLINT_CMP_HI_OFS}, '0, r);
        check_eq(r, rd, "mtimecmp high half");

        // print words mixed with unknown commands, top bit set
        last_word = '0;
        for (int i = 0; i < N_CHARS; i++) begin
            r    = rand_word();
            word = r[0] ? {`CMD_PRINT_CHAR, r[31:16]} : {1'b1, r[30:16], r[15:0]};
            if (word[31:16] == `CMD_PRINT_CHAR) begin
                chars_exp.push_back(word[7:0]);
            end
            reg_access(1'b1, {`DEV_TOHOST, `TOHOST_OFS}, word, rd);
            last_word = word;
            repeat (2) @(negedge CLK);
            check_eq(chars_seen.size(), chars_exp.size(), "character pulses so far");
        end
        for (int i = 0; i < chars_exp.size() && i < chars_seen.size(); i++) begin
            check_eq(chars_seen[i], chars_exp[i], "printed character");
        end
        check_eq(o_finish, 0, "finish before power off");
        reg_access(1'b0, {`DEV_TOHOST, `TOHOST_OFS}, '0, rd);
        check_eq(rd, last_word, "tohost read back");

        r = rand_word();
        reg_access(1'b1, {`DEV_TOHOST, `TOHOST_OFS}, {`CMD_POWER_OFF, r[15:0]}, rd);
        @(negedge CLK);
        check_eq(o_finish, 1, "finish after power off");
        reg_access(1'b1, {`DEV_TOHOST, `TOHOST_OFS}, {16'h8000, r[31:16]}, rd);
        reg_access(1'b0, {`DEV_TOHOST, `TOHOST_OFS}, '0, rd);
        check_eq(rd, {16'h8000, r[31:16]}, "tohost read back after power off");
        repeat (2) @(negedge CLK);
        check_eq(o_finish, 1, "finish stays high");
        check_eq(chars_seen.size(), chars_exp.size(), "character pulses in total");

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(200 * N_XFERS);
        $display("timeout: tests still running after %0d ns", 200 * N_XFERS);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
source/periph_pkg.sv
source/periph_bus_ctrl.sv
source/clint_timer.sv
source/plic_core.sv
source/tohost_unit.sv
source/periph_top.sv
test/tb_periph.sv
